// File: rtl/hex_dump.sv
`timescale 1ns/1ps

module hex_dump
    import serial_pkg::*;
    import signal_pkg::*;
#(
    parameter int CLKS_PER_BIT = 40000
) (
    input  logic         clk,
    input  logic         i_reset,
    input  logic         i_trig,
    input  rx_byte_t     i_cmd,
    input  sample_pair_t i_samples,
    output logic         o_tx
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(CLKS_PER_BIT - 1);

    uart_tx_state_e   state;
    logic             capturing;
    logic [1:0]       cap_cnt;
    logic             send_go;
    byte_t            cap;
    logic [1:0]       char_idx;
    logic [1:0]       load_idx;
    logic [2:0]       bit_idx;
    logic [CNT_W-1:0] clk_cnt;
    byte_t            tx_shift;
    byte_t            next_char;
    logic             bit_end;
    logic             busy;
    logic             take;

    function automatic byte_t hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return byte_t'(8'h30 + nib);
        end
        return byte_t'(8'h37 + nib);   // Upper case letters
    endfunction

    assign bit_end  = (clk_cnt == FULL);
    assign busy     = capturing | send_go | (state != TX_IDLE);
    assign take     = i_trig & ~i_cmd.err & ~busy;
    assign load_idx = (state == TX_IDLE) ? 2'd0 : char_idx + 2'd1;

    always_comb begin
        case (load_idx)
            2'd0:    next_char = hex_char(cap[7:4]);
            2'd1:    next_char = hex_char(cap[3:0]);
            default: next_char = 8'h0d;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            capturing <= 1'b0;
            cap_cnt   <= '0;
            send_go   <= 1'b0;
        end else begin
            send_go <= capturing && (cap_cnt == 2'd3);
            if (take) begin
                capturing <= 1'b1;
                cap_cnt   <= '0;
            end else if (capturing) begin
                cap_cnt <= cap_cnt + 1'b1;
                if (cap_cnt == 2'd3) begin
                    capturing <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capturing) begin
            cap <= {cap[5:0], i_samples.sig0, i_samples.sig1};  // MSB first
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state    <= TX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            char_idx <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    clk_cnt <= '0;
                    if (send_go) begin
                        char_idx <= '0;
                        state    <= TX_START;
                    end
                end
                TX_START: begin
                    clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
                    if (bit_end) begin
                        bit_idx <= '0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                        end
                    end
                end
                default: begin
                    clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
                    if (bit_end) begin
                        if (char_idx == 2'd2) begin
                            state <= TX_IDLE;   // Carriage return was the last one
                        end else begin
                            char_idx <= char_idx + 1'b1;
                            state    <= TX_START;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == TX_IDLE && send_go) || (state == TX_STOP && bit_end)) begin
            tx_shift <= next_char;
        end else if (state == TX_DATA && bit_end) begin
            tx_shift <= tx_shift >> 1;
        end
    end

    always_comb begin
        case (state)
            TX_START: o_tx = 1'b0;
            TX_DATA:  o_tx = tx_shift[0];
            default:  o_tx = 1'b1;     // Idle and stop bit
        endcase
    end

endmodule

// File: rtl/lvds_digitizer.sv
`timescale 1ns/1ps

module lvds_digitizer
    import signal_pkg::*;
#(
    parameter int ACT_W = 16
) (
    input  logic clk,
    input  logic i_reset,
    input  logic i_lvds,
    output logic o_sig,
    output logic o_active
);

    logic [1:0]       sync;            // Two-flop synchronizer
    logic [1:0]       hist;
    maj_win_t         taps;
    logic             vote;
    logic [ACT_W-1:0] act_cnt;

    assign taps = {hist, sync[1]};
    assign vote = (taps[0] & taps[1]) | (taps[1] & taps[2]) | (taps[0] & taps[2]);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            sync  <= '0;
            hist  <= '0;
            o_sig <= 1'b0;
        end else begin
            sync  <= {sync[0], i_lvds};
            hist  <= {hist[0], sync[1]};
            o_sig <= vote;             // Two of three agreeing taps win
        end
    end

    // The timeout restarts whenever the filtered bit is about to change
    always_ff @(posedge clk) begin
        if (i_reset) begin
            act_cnt  <= '0;
            o_active <= 1'b0;
        end else if (vote != o_sig) begin
            act_cnt  <= '0;
            o_active <= 1'b1;
        end else if (o_active) begin
            act_cnt <= act_cnt + 1'b1;
            if (&act_cnt) begin
                o_active <= 1'b0;      // Quiet for a full counter period
            end
        end
    end

endmodule

// File: rtl/pwm_adjust.sv
`timescale 1ns/1ps

module pwm_adjust
    import signal_pkg::*;
(
    input  logic  clk,
    input  logic  i_reset,
    input  duty_t i_duty,
    input  logic  i_sig,
    output logic  o_pwm
);

    pwm_cnt_t cnt;
    duty_t    shadow;
    logic     wrap;

    assign wrap = (cnt == 8'hff);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;         // Free running over 256 clocks
        end
    end

    // A new duty is only picked up at the period boundary, so no window is cut short
    always_ff @(posedge clk) begin
        if (i_reset) begin
            shadow <= '0;
        end else if (wrap) begin
            shadow <= i_duty;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_pwm <= 1'b0;
        end else begin
            o_pwm <= i_sig && (cnt < shadow);  // Gated by the filtered channel
        end
    end

endmodule

// File: rtl/rx_frontend_top.sv
`timescale 1ns/1ps

module rx_frontend_top
    import serial_pkg::*;
    import signal_pkg::*;
#(
    parameter int CLKS_PER_BIT = 40000,
    parameter int ACT_W        = 16
) (
    input  logic clk,
    input  logic i_reset,
    input  logic i_lvds0,
    input  logic i_lvds1,
    input  logic i_uart_rx,
    input  logic i_spi_sck,
    input  logic i_spi_cs_n,
    input  logic i_spi_mosi,
    output logic o_uart_tx,
    output logic o_spi_miso,
    output logic o_pwm,
    output logic o_led_oe
);

    logic         sig0;
    logic         sig1;
    logic         act0;
    sample_pair_t samples;
    logic         rx_valid;
    rx_byte_t     rx_byte;
    duty_t        duty;

    lvds_digitizer #(.ACT_W(ACT_W)) u_dig0 (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_lvds   (i_lvds0),
        .o_sig    (sig0),
        .o_active (act0)
    );

    lvds_digitizer #(.ACT_W(ACT_W)) u_dig1 (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_lvds   (i_lvds1),
        .o_sig    (sig1),
        .o_active ()                   // Only channel 0 drives the LED
    );

    assign samples  = '{sig0: sig0, sig1: sig1};
    assign o_led_oe = act0;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
        .clk     (clk),
        .i_reset (i_reset),
        .i_rx    (i_uart_rx),
        .o_valid (rx_valid),
        .o_byte  (rx_byte)
    );

    hex_dump #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_hex_dump (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_trig    (rx_valid),
        .i_cmd     (rx_byte),
        .i_samples (samples),
        .o_tx      (o_uart_tx)
    );

    spi_param_port u_spi (
        .clk     (clk),
        .i_reset (i_reset),
        .i_sck   (i_spi_sck),
        .i_cs_n  (i_spi_cs_n),
        .i_mosi  (i_spi_mosi),
        .o_miso  (o_spi_miso),
        .o_duty  (duty)
    );

    pwm_adjust u_pwm (
        .clk     (clk),
        .i_reset (i_reset),
        .i_duty  (duty),
        .i_sig   (sig0),               // PWM follows channel 0
        .o_pwm   (o_pwm)
    );

endmodule

// File: rtl/serial_pkg.sv
package serial_pkg;

    typedef logic [7:0] byte_t;        // One data byte on a UART or SPI link

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } uart_rx_state_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } uart_tx_state_e;

    typedef struct packed {
        byte_t data;
        logic  err;                    // Stop bit was sampled low
    } rx_byte_t;

endpackage

// File: rtl/signal_pkg.sv
package signal_pkg;

    typedef logic [7:0] duty_t;        // High cycles out of 256 where zero keeps the output low

    typedef logic [7:0] pwm_cnt_t;

    typedef logic [2:0] maj_win_t;     // Three taps seen by the majority vote

    // Filtered comparator channels where sig0 goes first when packing a byte
    typedef struct packed {
        logic sig0;
        logic sig1;
    } sample_pair_t;

endpackage

// File: rtl/spi_param_port.sv
`timescale 1ns/1ps

module spi_param_port
    import serial_pkg::*;
    import signal_pkg::*;
(
    input  logic  clk,
    input  logic  i_reset,
    input  logic  i_sck,
    input  logic  i_cs_n,
    input  logic  i_mosi,
    output logic  o_miso,
    output duty_t o_duty
);

    logic [2:0] sck_s;                 // Bit 2 holds the previous synchronized level
    logic [2:0] cs_s;
    logic [1:0] mosi_s;
    logic       sck_rise;
    logic       sck_fall;
    logic       cs_fall;
    logic       cs_act;
    logic       byte_done;
    logic [2:0] bit_cnt;
    logic       first;                 // Still waiting for the first byte of the frame
    byte_t      rx_shift;
    byte_t      rx_next;
    byte_t      tx_shift;
    byte_t      echo;

    assign sck_rise  = sck_s[1] & ~sck_s[2];
    assign sck_fall  = ~sck_s[1] & sck_s[2];
    assign cs_fall   = ~cs_s[1] & cs_s[2];
    assign cs_act    = ~cs_s[1];
    assign rx_next   = {rx_shift[6:0], mosi_s[1]};
    assign byte_done = cs_act & sck_rise & (bit_cnt == 3'd7);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            sck_s   <= '0;
            cs_s    <= '1;
            mosi_s  <= '0;
            bit_cnt <= '0;
            first   <= 1'b0;
            o_duty  <= '0;
        end else begin
            sck_s  <= {sck_s[1:0], i_sck};
            cs_s   <= {cs_s[1:0], i_cs_n};
            mosi_s <= {mosi_s[0], i_mosi};  // Same depth as SCK keeps them aligned
            if (cs_fall) begin
                bit_cnt <= '0;
                first   <= 1'b1;
            end else if (cs_act && sck_rise) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (byte_done && first) begin
                o_duty <= rx_next;
                first  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cs_act && sck_rise) begin
            rx_shift <= rx_next;
        end
        if (byte_done) begin
            echo <= rx_next;
        end
        if (cs_fall) begin
            tx_shift <= '0;            // Byte 0 of a frame has nothing to echo
        end else if (cs_act && sck_fall) begin
            tx_shift <= (bit_cnt == 3'd0) ? echo : tx_shift << 1;
        end
    end

    assign o_miso = cs_act & tx_shift[7];

endmodule

// File: rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
    import serial_pkg::*;
#(
    parameter int CLKS_PER_BIT = 40000
) (
    input  logic     clk,
    input  logic     i_reset,
    input  logic     i_rx,
    output logic     o_valid,
    output rx_byte_t o_byte
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(CLKS_PER_BIT - 1);

    uart_rx_state_e   state;
    logic [2:0]       rx_sync;         // Bit 1 is the synchronized line, bit 2 the previous one
    logic             rx_s;
    logic             rx_fall;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    byte_t            shift;
    logic             mid_bit;

    assign rx_s    = rx_sync[1];
    assign rx_fall = rx_sync[2] & ~rx_sync[1];
    assign mid_bit = (clk_cnt == FULL);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            rx_sync <= '1;
            state   <= RX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            o_valid <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[1:0], i_rx};
            o_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (rx_fall) begin
                        state <= RX_START;  // Only an edge starts a frame
                    end
                end
                RX_START: begin
                    if (clk_cnt == HALF) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? RX_IDLE : RX_DATA;  // Drop short glitches
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (mid_bit) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    if (mid_bit) begin
                        clk_cnt <= '0;
                        o_valid <= 1'b1;
                        state   <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_DATA && mid_bit) begin
            shift <= {rx_s, shift[7:1]};    // LSB arrives first
        end
        if (state == RX_STOP && mid_bit) begin
            o_byte <= '{data: shift, err: ~rx_s};
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line in its output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module rx_frontend_tb \
    && ./obj_dir/Vrx_frontend_tb | tee /dev/stderr | grep -x "ALL CHECKS PASSED" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: test/rx_frontend_assert.sv
`timescale 1ns/1ps

module rx_frontend_assert
    import signal_pkg::*;
#(
    parameter int CLKS_PER_BIT = 16
) (
    input logic  clk,
    input logic  i_reset,
    input logic  i_uart_tx,
    input logic  i_spi_miso,
    input logic  i_pwm,
    input logic  i_led_oe,
    input duty_t i_duty
);

    localparam int STOP_MID = 9 * CLKS_PER_BIT + CLKS_PER_BIT / 2;

    int frame_left;                    // Clocks left until the middle of the stop bit
    int err_cnt = 0;

    // A low line while no frame is open is taken as a start bit
    always_ff @(posedge clk) begin
        if (i_reset) begin
            frame_left <= 0;
        end else if (frame_left != 0) begin
            frame_left <= frame_left - 1;
        end else if (!i_uart_tx) begin
            frame_left <= STOP_MID;
        end
    end

    reset_idle: assert property (@(posedge clk)
        $past(i_reset) |-> (i_uart_tx && !i_pwm && !i_spi_miso && !i_led_oe))
    else begin
        err_cnt++;
        $error("Outputs not at their idle levels during or right after reset");
    end

    pwm_off_at_zero: assert property (@(posedge clk) disable iff (i_reset)
        (i_duty == 8'h00) |-> !i_pwm)
    else begin
        err_cnt++;
        $error("o_pwm high while the duty is zero");
    end

    stop_bit_high: assert property (@(posedge clk) disable iff (i_reset)
        (frame_left == 1) |-> i_uart_tx)
    else begin
        err_cnt++;
        $error("Stop bit on o_uart_tx sampled low");
    end

endmodule

bind rx_frontend_top rx_frontend_assert #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_assert (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_uart_tx  (o_uart_tx),
    .i_spi_miso (o_spi_miso),
    .i_pwm      (o_pwm),
    .i_led_oe   (o_led_oe),
    .i_duty     (duty)
);

// File: test/rx_frontend_tb.sv
`timescale 1ns/1ps

module rx_frontend_tb
    import serial_pkg::*;
;

    localparam int CPB      = 16;
    localparam int ACT_W    = 6;
    localparam int SPI_HALF = 8;       // SCK half period in clocks
    localparam int SPI_CLKS = 56 * SPI_HALF;
    localparam int PWM_CLKS = 3 * (300 + 256) + 10;
    localparam int DUMP_CLKS = 20 + 42 * CPB;
    localparam int RUN_CLKS = 8 + 300 + 2 * SPI_CLKS + PWM_CLKS + 2 * DUMP_CLKS + 51 * CPB
                              + 12 * 8 + (1 << ACT_W) + 18;

    logic        clk;
    logic        i_reset;
    logic        i_lvds0;
    logic        i_lvds1;
    logic        i_uart_rx;
    logic        i_spi_sck;
    logic        i_spi_cs_n;
    logic        i_spi_mosi;
    logic        o_uart_tx;
    logic        o_spi_miso;
    logic        o_pwm;
    logic        o_led_oe;
    logic [31:0] rng = 32'hb2c0;
    int          errors = 0;
    int          checks = 0;
    int          pwm_high;
    byte_t       spi_tx [0:2];
    byte_t       spi_rx [0:2];

    tb_clock u_clk (.o_clk(clk));

    rx_frontend_top #(.CLKS_PER_BIT(CPB), .ACT_W(ACT_W)) uut (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_lvds0    (i_lvds0),
        .i_lvds1    (i_lvds1),
        .i_uart_rx  (i_uart_rx),
        .i_spi_sck  (i_spi_sck),
        .i_spi_cs_n (i_spi_cs_n),
        .i_spi_mosi (i_spi_mosi),
        .o_uart_tx  (o_uart_tx),
        .o_spi_miso (o_spi_miso),
        .o_pwm      (o_pwm),
        .o_led_oe   (o_led_oe)
    );

    function automatic byte_t rand_byte();
        rng = rng * 32'd1103515245 + 32'd12345;
        return rng[23:16];
    endfunction

    function automatic byte_t rand_duty();
        byte_t b;
        b = rand_byte();
        if (b == 8'h00) begin
            b = 8'h01;                 // A zero duty would leave nothing to count
        end
        return b;
    endfunction

    task automatic compare_value(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic expect_event(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    task automatic hold_clocks(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic send_uart_byte(input byte_t data, input logic bad_stop);
        byte_t sh;
        sh = data;
        i_uart_rx = 1'b0;
        hold_clocks(CPB);
        repeat (8) begin
            i_uart_rx = sh[0];         // LSB first
            sh = sh >> 1;
            hold_clocks(CPB);
        end
        i_uart_rx = ~bad_stop;
        hold_clocks(CPB);
        i_uart_rx = 1'b1;
        hold_clocks(CPB);
    endtask

    task automatic recv_uart_byte(input int max_wait, output byte_t b, output logic got);
        int n;
        n = 0;
        b = '0;
        got = 1'b0;
        while (o_uart_tx && n < max_wait) begin
            @(negedge clk);
            n++;
        end
        if (!o_uart_tx) begin
            got = 1'b1;
            hold_clocks(CPB / 2);
            repeat (8) begin
                hold_clocks(CPB);
                b = {o_uart_tx, b[7:1]};
            end
            hold_clocks(CPB);          // Middle of the stop bit
        end
    endtask

    task automatic drive_spi_frame(input int nbytes);
        byte_t sh;
        byte_t got;
        i_spi_cs_n = 1'b0;
        hold_clocks(2 * SPI_HALF);
        for (int k = 0; k < nbytes; k++) begin
            sh = spi_tx[k];
            got = '0;
            repeat (8) begin
                i_spi_mosi = sh[7];
                sh = sh << 1;
                hold_clocks(SPI_HALF);
                got = {got[6:0], o_spi_miso};  // Sampled as SCK rises
                i_spi_sck = 1'b1;
                hold_clocks(SPI_HALF);
                i_spi_sck = 1'b0;
            end
            spi_rx[k] = got;
        end
        hold_clocks(2 * SPI_HALF);
        i_spi_cs_n = 1'b1;
        hold_clocks(2 * SPI_HALF);
    endtask

    task automatic count_pwm_high(output int n);
        n = 0;
        repeat (256) begin
            @(negedge clk);
            if (o_pwm) begin
                n++;
            end
        end
    endtask

    task automatic check_dump(input logic l0, input logic l1, input byte_t digit);
        byte_t c0;
        byte_t c1;
        byte_t c2;
        logic  g0;
        logic  g1;
        logic  g2;
        i_lvds0 = l0;
        i_lvds1 = l1;
        hold_clocks(10);
        fork
            send_uart_byte(8'h3c, 1'b0);
            begin
                recv_uart_byte(12 * CPB, c0, g0);
                recv_uart_byte(2 * CPB, c1, g1);
                recv_uart_byte(2 * CPB, c2, g2);
            end
        join
        expect_event(g0 && g1 && g2, "Hex dump did not send three frames on o_uart_tx");
        compare_value("o_uart_tx high digit", int'(c0), int'(digit));
        compare_value("o_uart_tx low digit", int'(c1), int'(digit));
        compare_value("o_uart_tx line end", int'(c2), 32'h0d);
    endtask

    task automatic check_framing_drop();
        logic saw_start;
        saw_start = 1'b0;
        fork
            send_uart_byte(8'hc3, 1'b1);
            begin
                repeat (50 * CPB) begin
                    @(negedge clk);
                    if (!o_uart_tx) begin
                        saw_start = 1'b1;
                    end
                end
            end
        join
        expect_event(!saw_start, "A byte with a low stop bit started a reply on o_uart_tx");
    endtask

    initial begin
        i_reset    = 1'b1;
        i_lvds0    = 1'b0;
        i_lvds1    = 1'b0;
        i_uart_rx  = 1'b1;
        i_spi_sck  = 1'b0;
        i_spi_cs_n = 1'b1;
        i_spi_mosi = 1'b0;
        hold_clocks(8);
        i_reset = 1'b0;
        hold_clocks(4);

        i_lvds0 = 1'b1;
        hold_clocks(300);              // A full PWM period with zero duty and channel 0 high
        spi_tx[0] = rand_duty();
        spi_tx[1] = rand_byte();
        spi_tx[2] = rand_byte();
        drive_spi_frame(3);
        compare_value("o_spi_miso byte 0", int'(spi_rx[0]), 0);
        compare_value("o_spi_miso byte 1", int'(spi_rx[1]), int'(spi_tx[0]));
        compare_value("o_spi_miso byte 2", int'(spi_rx[2]), int'(spi_tx[1]));
        hold_clocks(300);
        count_pwm_high(pwm_high);
        compare_value("o_pwm high cycles", pwm_high, int'(spi_tx[0]));

        spi_tx[0] = rand_duty();
        spi_tx[1] = rand_byte();
        drive_spi_frame(2);
        compare_value("o_spi_miso byte 0", int'(spi_rx[0]), 0);
        compare_value("o_spi_miso byte 1", int'(spi_rx[1]), int'(spi_tx[0]));
        hold_clocks(300);
        count_pwm_high(pwm_high);
        compare_value("o_pwm high cycles", pwm_high, int'(spi_tx[0]));

        i_lvds0 = 1'b0;                // Channel 0 low gates the PWM off
        hold_clocks(10);
        count_pwm_high(pwm_high);
        compare_value("o_pwm gated high cycles", pwm_high, 0);

        check_dump(1'b1, 1'b0, 8'h41);
        check_dump(1'b0, 1'b1, 8'h35);
        hold_clocks(CPB);
        check_framing_drop();

        for (int t = 0; t < 12; t++) begin
            i_lvds0 = ~i_lvds0;
            hold_clocks(8);
            if (t >= 1) begin
                compare_value("o_led_oe while toggling", int'(o_led_oe), 1);
            end
        end
        hold_clocks((1 << ACT_W) + 10);
        compare_value("o_led_oe after quiet input", int'(o_led_oe), 0);

        $display("Checks: %0d run, %0d failed, %0d assertion failures",
                 checks, errors, uut.u_assert.err_cnt);
        if (errors == 0 && uut.u_assert.err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (2 * RUN_CLKS) @(posedge clk);
        $display("Watchdog: the run did not finish within %0d clocks", 2 * RUN_CLKS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_NS = 50
) (
    output logic o_clk
);

    initial o_clk = 1'b0;

    always #(HALF_NS) o_clk = ~o_clk;  // 100 ns period

endmodule

// File: vlog.f
rtl/serial_pkg.sv
rtl/signal_pkg.sv
rtl/lvds_digitizer.sv
rtl/pwm_adjust.sv
rtl/uart_rx.sv
rtl/hex_dump.sv
rtl/spi_param_port.sv
rtl/rx_frontend_top.sv
test/tb_clock.sv
test/rx_frontend_assert.sv
test/rx_frontend_tb.sv
